/* Makefile */
TOOL := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP := whizGraphicsTb
FILELIST := compile.f

BUILD := obj_dir
SIM := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

clean:
	rm -rf $(BUILD)

/* compile.f */
+incdir+source
source/videoTypes.sv
source/videoRegisters.sv
source/lineSequencer.sv
source/backgroundFetch.sv
source/spriteFetch.sv
source/pixelMixer.sv
source/whizGraphics.sv
verification/whizGraphicsTb.sv

/* source/backgroundFetch.sv */
`timescale 1ns/100ps
`include "video_cfg.svh"

module backgroundFetch (
   input logic cntrl,
   input logic reset,
   input videoTypes::videoStateT state,
   input videoTypes::pixelPosT pos,
   output videoTypes::pixelPosT posOut,
   output videoTypes::colorT bgColor
);

   localparam int bgBits = $clog2(`BG_SIZE);
   localparam int rowBits = $clog2(`TILE_SIZE);
   localparam int tileBits = $clog2(`NUM_TILES);

   videoTypes::coordT sumX;
   videoTypes::coordT sumY;
   logic [bgBits-1:0] bgX;
   logic [bgBits-1:0] bgY;
   videoTypes::byteT tileIndex;
   videoTypes::colorT pixelColor;

   assign sumX = pos.x + state.scrollX;
   assign sumY = pos.y + state.scrollY;

   // background is a power of two wide, so the low bits wrap it
   assign bgX = sumX[bgBits-1:0];
   assign bgY = sumY[bgBits-1:0];

   // row-major map lookup
   assign tileIndex = state.tileMap[{bgY[bgBits-1:rowBits], bgX[bgBits-1:rowBits]}];

   assign pixelColor = videoTypes::tilePixel(state.tiles[tileIndex[tileBits-1:0]],
                                             bgY[rowBits-1:0], bgX[rowBits-1:0]);

   always_ff @(posedge cntrl) begin
      bgColor <= pixelColor;
      posOut.x <= pos.x;
      posOut.y <= pos.y;
      if (reset) begin
         posOut.active <= 1'b0;
      end else begin
         posOut.active <= pos.active;
      end
   end

endmodule

/* source/lineSequencer.sv */
`timescale 1ns/100ps
`include "video_cfg.svh"

module lineSequencer (
   input logic cntrl,
   input logic reset,
   output videoTypes::pixelPosT pos,
   output videoTypes::lcdModeT lcdMode,
   output logic renderComplete
);

   localparam int totalLines = `LCD_LINES + `VBLANK_LINES;

   logic [$clog2(`CLOCKS_PER_LINE)-1:0] clockCount;
   logic [$clog2(totalLines)-1:0] lineCount;
   logic visibleLine;
   logic activeClock;

   always_ff @(posedge cntrl) begin
      if (reset) begin
         clockCount <= '0;
         lineCount <= '0;
      end else if (clockCount == `CLOCKS_PER_LINE - 1) begin
         clockCount <= '0;
         if (lineCount == totalLines - 1) begin
            lineCount <= '0;
         end else begin
            lineCount <= lineCount + 1'b1;
         end
      end else begin
         clockCount <= clockCount + 1'b1;
      end
   end

   assign visibleLine = lineCount < `LCD_LINES;
   assign activeClock = clockCount < `LCD_WIDTH;

   assign pos.x = videoTypes::coordT'(clockCount);
   assign pos.y = videoTypes::coordT'(lineCount);
   assign pos.active = visibleLine && activeClock;

   // vblank covers whole lines, hblank is the tail of a visible line
   assign lcdMode = !visibleLine ? videoTypes::renderVblank :
                    activeClock ? videoTypes::renderActive : videoTypes::renderHblank;
   assign renderComplete = !visibleLine;

endmodule

/* source/pixelMixer.sv */
`timescale 1ns/100ps

module pixelMixer (
   input logic cntrl,
   input logic reset,
   input videoTypes::videoStateT state,
   input videoTypes::pixelPosT pos,
   input videoTypes::colorT bgColor,
   input videoTypes::colorT spriteColor,
   input logic spriteHit,
   output logic pixelValid,
   output videoTypes::coordT pixelX,
   output videoTypes::coordT pixelY,
   output videoTypes::colorT pixelColor
);

   videoTypes::byteT palette;
   videoTypes::colorT shadeIndex;
   videoTypes::colorT shade;

   // sprite pixel covers the background only where it is opaque
   assign palette = spriteHit ? state.spritePalette : state.bgPalette;
   assign shadeIndex = spriteHit ? spriteColor : bgColor;
   assign shade = state.lcdControl.lcdEnable ? palette[{shadeIndex, 1'b0} +: 2] : 2'b00;

   always_ff @(posedge cntrl) begin
      pixelColor <= shade;
      pixelX <= pos.x;
      pixelY <= pos.y;
      if (reset) begin
         pixelValid <= 1'b0;
      end else begin
         pixelValid <= pos.active;
      end
   end

endmodule

/* source/spriteFetch.sv */
`timescale 1ns/100ps
`include "video_cfg.svh"

module spriteFetch (
   input logic cntrl,
   input logic reset,
   input videoTypes::videoStateT state,
   input videoTypes::pixelPosT pos,
   output videoTypes::colorT spriteColor,
   output logic spriteHit
);

   localparam int tileBits = $clog2(`NUM_TILES);

   videoTypes::colorT hitColor;
   logic hit;

   always_comb begin
      videoTypes::spriteAttrT sprite;
      videoTypes::coordT dy;
      videoTypes::coordT dx;
      videoTypes::colorT color;
      int taken;
      hitColor = '0;
      hit = 1'b0;
      taken = 0;
      // scan in index order, later sprites overwrite earlier ones
      for (int i = 0; i < `NUM_SPRITES; i++) begin
         sprite = state.sprites[i];
         dy = pos.y - sprite.yPosition;
         dx = pos.x - sprite.xPosition;
         color = videoTypes::tilePixel(state.tiles[sprite.tileIndex[tileBits-1:0]],
                                       dy[2:0], dx[2:0]);
         if (pos.y >= sprite.yPosition && dy < `TILE_SIZE &&
             taken < `MAX_SPRITES_PER_LINE) begin
            // counts against the line limit even when x misses
            taken = taken + 1;
            if (pos.x >= sprite.xPosition && dx < `TILE_SIZE && color != 2'b00) begin
               hit = 1'b1;
               hitColor = color;
            end
         end
      end
   end

   always_ff @(posedge cntrl) begin
      spriteColor <= hitColor;
      if (reset) begin
         spriteHit <= 1'b0;
      end else begin
         spriteHit <= hit && state.lcdControl.spriteEnable;
      end
   end

endmodule

/* source/videoRegisters.sv */
`timescale 1ns/100ps
`include "video_cfg.svh"

module videoRegisters (
   input logic cntrl,
   input logic reset,
   input logic busWrite,
   input logic busRead,
   input videoTypes::busAddrT busAddr,
   input videoTypes::byteT busWData,
   output videoTypes::byteT busRData,
   input videoTypes::lcdModeT lcdMode,
   output videoTypes::videoStateT state
);

   videoTypes::busAddrT tileOffset;
   videoTypes::busAddrT mapOffset;
   videoTypes::busAddrT oamOffset;
   logic inTiles;
   logic inMap;
   logic inOam;
   videoTypes::spriteAttrT oamEntry;
   videoTypes::byteT readData;

   // region offsets wrap below the base, so one compare per region
   assign tileOffset = busAddr - `TILES_ADDR;
   assign mapOffset = busAddr - `MAP_ADDR;
   assign oamOffset = busAddr - `OAM_ADDR;
   assign inTiles = tileOffset < `TILES_BYTES;
   assign inMap = mapOffset < `MAP_BYTES;
   assign inOam = oamOffset < `OAM_BYTES;
   assign oamEntry = state.sprites[oamOffset[3:2]];

   always_ff @(posedge cntrl) begin
      if (reset) begin
         state <= '0;
         // identity palettes
         state.bgPalette <= 8'hE4;
         state.spritePalette <= 8'hE4;
      end else if (busWrite) begin
         if (inTiles) begin
            state.tiles[tileOffset[7:4]][tileOffset[3:0]] <= busWData;
         end else if (inMap) begin
            state.tileMap[mapOffset[3:0]] <= busWData;
         end else if (inOam) begin
            case (oamOffset[1:0])
               2'd0: state.sprites[oamOffset[3:2]].yPosition <= busWData;
               2'd1: state.sprites[oamOffset[3:2]].xPosition <= busWData;
               2'd2: state.sprites[oamOffset[3:2]].tileIndex <= busWData;
               default: state.sprites[oamOffset[3:2]].spare <= busWData;
            endcase
         end else begin
            case (busAddr)
               `PALETTE_ADDR: state.bgPalette <= busWData;
               `PALETTE_ADDR + 9'd1: state.spritePalette <= busWData;
               `SCROLL_ADDR: state.scrollX <= busWData;
               `SCROLL_ADDR + 9'd1: state.scrollY <= busWData;
               `LCDC_ADDR: state.lcdControl <= busWData;
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      readData = '0;
      if (inTiles) begin
         readData = state.tiles[tileOffset[7:4]][tileOffset[3:0]];
      end else if (inMap) begin
         readData = state.tileMap[mapOffset[3:0]];
      end else if (inOam) begin
         case (oamOffset[1:0])
            2'd0: readData = oamEntry.yPosition;
            2'd1: readData = oamEntry.xPosition;
            2'd2: readData = oamEntry.tileIndex;
            default: readData = oamEntry.spare;
         endcase
      end else begin
         case (busAddr)
            `PALETTE_ADDR: readData = state.bgPalette;
            `PALETTE_ADDR + 9'd1: readData = state.spritePalette;
            `SCROLL_ADDR: readData = state.scrollX;
            `SCROLL_ADDR + 9'd1: readData = state.scrollY;
            `LCDC_ADDR: readData = state.lcdControl;
            `STAT_ADDR: readData = {6'b000000, lcdMode};
            default: readData = '0;
         endcase
      end
   end

   // read data shows up the cycle after the strobe
   always_ff @(posedge cntrl) begin
      if (reset) begin
         busRData <= '0;
      end else if (busRead) begin
         busRData <= readData;
      end
   end

endmodule

/* source/videoTypes.sv */
package videoTypes;

`include "video_cfg.svh"

   typedef logic [8:0] busAddrT;
   typedef logic [7:0] byteT;
   typedef logic [1:0] colorT;
   typedef logic [7:0] coordT;

   typedef enum logic [1:0] {
      renderHblank = 2'd0,
      renderVblank = 2'd1,
      renderActive = 2'd2
   } lcdModeT;

   typedef struct packed {
      logic [5:0] reserved;
      logic spriteEnable;
      logic lcdEnable;
   } lcdControlT;

   typedef struct packed {
      byteT spare;
      byteT tileIndex;
      byteT xPosition;
      byteT yPosition;
   } spriteAttrT;

   // byte 2r is the low plane of row r, byte 2r+1 the high plane
   typedef byteT [`TILE_BYTES-1:0] tileT;

   typedef struct packed {
      tileT [`NUM_TILES-1:0] tiles;
      byteT [`MAP_TILES*`MAP_TILES-1:0] tileMap;
      spriteAttrT [`NUM_SPRITES-1:0] sprites;
      byteT bgPalette;
      byteT spritePalette;
      byteT scrollX;
      byteT scrollY;
      lcdControlT lcdControl;
   } videoStateT;

   typedef struct packed {
      coordT x;
      coordT y;
      logic active;
   } pixelPosT;

   // pixel 0 sits in bit 7, high plane gives the upper colour bit
   function automatic colorT tilePixel(tileT tile, logic [2:0] row, logic [2:0] col);
      byteT lowPlane;
      byteT highPlane;
      lowPlane = tile[{row, 1'b0}];
      highPlane = tile[{row, 1'b1}];
      return {highPlane[3'd7 - col], lowPlane[3'd7 - col]};
   endfunction

endpackage

/* source/video_cfg.svh */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// visible screen and line timing
`define LCD_WIDTH 16
`define LCD_LINES 16
`define VBLANK_LINES 2
`define CLOCKS_PER_LINE 24

// tile and map geometry
`define TILE_SIZE 8
`define TILE_BYTES 16
`define NUM_TILES 16
`define MAP_TILES 4
`define BG_SIZE (`MAP_TILES * `TILE_SIZE)

// sprite table
`define NUM_SPRITES 4
`define MAX_SPRITES_PER_LINE 2

// bus address map
`define TILES_ADDR 9'h000
`define TILES_BYTES 256
`define MAP_ADDR 9'h100
`define MAP_BYTES 16
`define OAM_ADDR 9'h110
`define OAM_BYTES 16
`define PALETTE_ADDR 9'h120
`define SCROLL_ADDR 9'h122
`define LCDC_ADDR 9'h124
`define STAT_ADDR 9'h125

`endif

/* source/whizGraphics.sv */
`timescale 1ns/100ps

module whizGraphics (
   input logic cntrl,
   input logic reset,
   input logic busWrite,
   input logic busRead,
   input videoTypes::busAddrT busAddr,
   input videoTypes::byteT busWData,
   output videoTypes::byteT busRData,
   output logic pixelValid,
   output videoTypes::coordT pixelX,
   output videoTypes::coordT pixelY,
   output videoTypes::colorT pixelColor,
   output logic renderComplete,
   output videoTypes::lcdModeT lcdMode
);

   videoTypes::videoStateT state;
   videoTypes::pixelPosT pos;
   videoTypes::pixelPosT fetchPos;
   videoTypes::colorT bgColor;
   videoTypes::colorT spriteColor;
   logic spriteHit;

   videoRegisters videoRegisters_i (
      .cntrl(cntrl),
      .reset(reset),
      .busWrite(busWrite),
      .busRead(busRead),
      .busAddr(busAddr),
      .busWData(busWData),
      .busRData(busRData),
      .lcdMode(lcdMode),
      .state(state)
   );

   lineSequencer lineSequencer_i (
      .cntrl(cntrl),
      .reset(reset),
      .pos(pos),
      .lcdMode(lcdMode),
      .renderComplete(renderComplete)
   );

   // both fetch stages see the same position in the same cycle
   backgroundFetch backgroundFetch_i (
      .cntrl(cntrl),
      .reset(reset),
      .state(state),
      .pos(pos),
      .posOut(fetchPos),
      .bgColor(bgColor)
   );

   spriteFetch spriteFetch_i (
      .cntrl(cntrl),
      .reset(reset),
      .state(state),
      .pos(pos),
      .spriteColor(spriteColor),
      .spriteHit(spriteHit)
   );

   pixelMixer pixelMixer_i (
      .cntrl(cntrl),
      .reset(reset),
      .state(state),
      .pos(fetchPos),
      .bgColor(bgColor),
      .spriteColor(spriteColor),
      .spriteHit(spriteHit),
      .pixelValid(pixelValid),
      .pixelX(pixelX),
      .pixelY(pixelY),
      .pixelColor(pixelColor)
   );

endmodule

/* verification/render_tests.txt */
# W addr data: bus write, R addr data: read and compare, both hex (status compares with lcdMode)
# F: check one whole frame, then P x y shade (decimal) checks a pixel of that frame
R 120 E4
R 121 E4
R 124 00
R 125 00
R 130 00
W 030 F0
W 031 CC
W 010 FF
W 104 03
W 105 03
W 130 5A
R 130 00
R 1FF 00
R 031 CC
R 105 03
F
W 110 02
W 112 03
W 114 02
W 115 04
W 116 03
W 118 02
W 119 0C
W 11A 01
R 115 04
W 120 1B
R 120 1B
W 122 1C
W 123 1A
R 123 1A
W 124 03
R 124 03
F
P 4 14 0
P 8 14 1
P 11 14 3
P 13 14 0
P 15 14 2
P 2 2 1
P 4 2 3
P 6 2 1
P 8 2 2
P 10 2 3
P 12 2 3
W 124 01
F
P 2 2 3
P 8 2 3
P 4 14 0

/* verification/whizGraphicsTb.sv */
`timescale 1ns/100ps
`include "video_cfg.svh"

module whizGraphicsTb;

   localparam int frameCycles = (`LCD_LINES + `VBLANK_LINES) * `CLOCKS_PER_LINE;
   localparam int vblankCycles = `VBLANK_LINES * `CLOCKS_PER_LINE;
   localparam int framePixels = `LCD_WIDTH * `LCD_LINES;

   logic cntrl;
   logic reset;
   logic busWrite;
   logic busRead;
   videoTypes::busAddrT busAddr;
   videoTypes::byteT busWData;
   videoTypes::byteT busRData;
   logic pixelValid;
   videoTypes::coordT pixelX;
   videoTypes::coordT pixelY;
   videoTypes::colorT pixelColor;
   logic renderComplete;
   videoTypes::lcdModeT lcdMode;

   // shades of the last captured frame, indexed by line then column
   int shades [`LCD_LINES][`LCD_WIDTH];
   // last control byte written over the bus
   int lcdControl;
   // position inside the frame, counted from the end of reset
   int frameCycle;

   whizGraphics whizGraphics_i (
      .cntrl(cntrl),
      .reset(reset),
      .busWrite(busWrite),
      .busRead(busRead),
      .busAddr(busAddr),
      .busWData(busWData),
      .busRData(busRData),
      .pixelValid(pixelValid),
      .pixelX(pixelX),
      .pixelY(pixelY),
      .pixelColor(pixelColor),
      .renderComplete(renderComplete),
      .lcdMode(lcdMode)
   );

   initial begin
      cntrl = 1'b0;
      forever #4 cntrl = ~cntrl;
   end

   task automatic abortRun();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkValue(input string name, input int got, input int expected);
      assert (got == expected) else begin
         $display("[ERROR] time %0t %s expected %0h got %0h", $time, name, expected, got);
         abortRun();
      end
   endtask

   // mode from the position inside the frame
   function automatic int modeAt(input int cycle);
      int lineNumber;
      int column;
      lineNumber = cycle / `CLOCKS_PER_LINE;
      column = cycle % `CLOCKS_PER_LINE;
      if (lineNumber >= `LCD_LINES) begin
         return int'(videoTypes::renderVblank);
      end else if (column < `LCD_WIDTH) begin
         return int'(videoTypes::renderActive);
      end
      return int'(videoTypes::renderHblank);
   endfunction

   always @(posedge cntrl) begin
      if (reset) begin
         frameCycle <= 0;
      end else begin
         frameCycle <= (frameCycle + 1) % frameCycles;
      end
   end

   always @(negedge cntrl) begin
      if (!reset) begin
         checkValue("lcdMode", int'(lcdMode), modeAt(frameCycle));
      end
   end

   task automatic writeBus(input int addr, input int data);
      @(posedge cntrl);
      busWrite <= 1'b1;
      busAddr <= videoTypes::busAddrT'(addr);
      busWData <= videoTypes::byteT'(data);
      @(posedge cntrl);
      busWrite <= 1'b0;
      if (addr == `LCDC_ADDR) begin
         lcdControl = data;
      end
   endtask

   task automatic readBus(input int addr, input int expected);
      int mode;
      int want;
      @(posedge cntrl);
      busRead <= 1'b1;
      busAddr <= videoTypes::busAddrT'(addr);
      @(negedge cntrl);
      // mode seen by the edge that takes the read
      mode = modeAt(frameCycle);
      @(posedge cntrl);
      busRead <= 1'b0;
      @(negedge cntrl);
      want = (addr == `STAT_ADDR) ? mode : expected;
      checkValue("busRData", int'(busRData), want);
   endtask

   task automatic waitComplete(input logic level, input int limit);
      int cycles;
      cycles = 0;
      while (renderComplete !== level) begin
         @(negedge cntrl);
         cycles++;
         if (cycles > limit) begin
            $display("timeout waiting for renderComplete to become %0d", level);
            abortRun();
         end
      end
   endtask

   task automatic captureFrame();
      int highCycles;
      int count;
      int cycles;
      @(negedge cntrl);
      waitComplete(1'b0, frameCycles);
      waitComplete(1'b1, frameCycles);
      highCycles = 0;
      while (renderComplete === 1'b1 && highCycles <= vblankCycles) begin
         checkValue("pixelValid", int'(pixelValid), 0);
         highCycles++;
         @(negedge cntrl);
      end
      checkValue("renderComplete high cycles", highCycles, vblankCycles);
      count = 0;
      cycles = 0;
      while (count < framePixels) begin
         if (pixelValid === 1'b1) begin
            checkValue("pixelX", int'(pixelX), count % `LCD_WIDTH);
            checkValue("pixelY", int'(pixelY), count / `LCD_WIDTH);
            // display off gives shade 0 everywhere
            if (lcdControl[0] == 1'b0) begin
               checkValue("pixelColor", int'(pixelColor), 0);
            end
            shades[count / `LCD_WIDTH][count % `LCD_WIDTH] = int'(pixelColor);
            count++;
         end
         @(negedge cntrl);
         cycles++;
         if (cycles > frameCycles) begin
            $display("timeout capturing a frame, only %0d pixels arrived", count);
            abortRun();
         end
      end
      // no extra pixel before the next vblank
      cycles = 0;
      while (renderComplete !== 1'b1) begin
         checkValue("pixelValid", int'(pixelValid), 0);
         @(negedge cntrl);
         cycles++;
         if (cycles > frameCycles) begin
            $display("timeout waiting for vblank after the frame");
            abortRun();
         end
      end
   endtask

   initial begin
      int fd;
      int code;
      int a;
      int b;
      int c;
      logic [8*16-1:0] word;
      logic [8*100-1:0] rest;
      reset = 1'b1;
      busWrite = 1'b0;
      busRead = 1'b0;
      busAddr = '0;
      busWData = '0;
      lcdControl = 0;
      repeat (2) @(posedge cntrl);
      reset <= 1'b0;
      fd = $fopen("verification/render_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open verification/render_tests.txt");
         abortRun();
      end
      while ($fscanf(fd, " %s", word) == 1) begin
         if (word == "#") begin
            code = $fgets(rest, fd);
         end else if (word == "W") begin
            code = $fscanf(fd, " %h %h", a, b);
            writeBus(a, b);
         end else if (word == "R") begin
            code = $fscanf(fd, " %h %h", a, b);
            readBus(a, b);
         end else if (word == "F") begin
            captureFrame();
         end else if (word == "P") begin
            code = $fscanf(fd, " %d %d %d", a, b, c);
            checkValue($sformatf("pixelColor at x %0d y %0d", a, b), shades[b][a], c);
         end else begin
            $display("unknown command %0s in the test file", word);
            abortRun();
         end
      end
      $fclose(fd);
      $display("RESULT: PASS");
      $finish;
   end

endmodule
